// ==== hw/afu_edge_pkg.sv ====
// Shared constants, line types, request header enums and beat structs of the AFU edge
`default_nettype none

package afu_edge_pkg;

    // Longest multi-line write, in beats
    localparam int MAX_BEATS = 4;

    // Requests a sender may still issue once it sees almost full
    localparam int ALM_FULL_THRESHOLD = 8;

    localparam int LINE_ADDR_BITS = 16;
    localparam int LINE_DATA_BITS = 64;

    // Encoded as the index of the last beat, so the value 2 never appears
    typedef enum logic [1:0]
    {
        len_1 = 2'd0,
        len_2 = 2'd1,
        len_4 = 2'd3
    } t_cl_len;

    // Beat number inside one packet
    typedef logic [1:0] t_cl_num;

    typedef logic [LINE_ADDR_BITS-1:0] t_line_addr;
    typedef logic [LINE_DATA_BITS-1:0] t_line_data;

    // One write beat as the accelerator sends it and as the host receives it
    typedef struct packed
    {
        logic valid;
        logic sop;
        t_line_addr address;
        t_cl_len cl_len;
        t_cl_num cl_num;
        t_line_data data;
    } t_wr_beat;

    // One read request, which covers cl_len lines starting at address
    typedef struct packed
    {
        logic valid;
        t_line_addr address;
        t_cl_len cl_len;
    } t_rd_req;

    // The single control packet of a write
    // Only the low bits of heap_idx are meaningful for a given heap size
    typedef struct packed
    {
        t_line_addr address;
        t_cl_len cl_len;
        logic [7:0] heap_idx;
    } t_wr_ctrl;

endpackage

`default_nettype wire

// ==== hw/write_heap_ctrl.sv ====
// Free-list allocator for write heap slots, with a reserve threshold
`default_nettype none

module write_heap_ctrl
  #(
    parameter int n_entries = 32,
    parameter int min_free_slots = 13
    )
   (
    input  logic clk,
    input  logic reset,

    // Take the slot offered on alloc_idx
    input  logic alloc,
    output logic [$clog2(n_entries)-1:0] alloc_idx,
    output logic not_full,

    // Return a slot once its write has left toward the host
    input  logic free,
    input  logic [$clog2(n_entries)-1:0] free_idx
    );

    localparam int idx_bits = $clog2(n_entries);
    localparam int cnt_bits = $clog2(n_entries + 1);

    typedef logic [idx_bits-1:0] t_idx;
    typedef logic [cnt_bits-1:0] t_cnt;

    localparam t_idx last_slot = t_idx'(n_entries - 1);

    // Circular list of free slot numbers
    // Allocation pops at head and freeing pushes at tail
    t_idx free_list [n_entries];
    t_idx head;
    t_idx tail;
    t_cnt free_count;

    // The slot at head is offered continuously, so every beat of a packet sees the same index
    assign alloc_idx = free_list[head];

    // Keep a reserve so that requests issued after almost full still find a slot
    assign not_full = (free_count > t_cnt'(min_free_slots));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            // Every slot starts out free
            for (int i = 0; i < n_entries; i++)
            begin
                free_list[i] <= t_idx'(i);
            end
            head <= '0;
            tail <= '0;
            free_count <= t_cnt'(n_entries);
        end
        else
        begin
            if (free)
            begin
                free_list[tail] <= free_idx;
                tail <= (tail == last_slot) ? '0 : tail + 1'b1;
            end

            if (alloc)
            begin
                head <= (head == last_slot) ? '0 : head + 1'b1;
            end

            if (free && !alloc)
            begin
                free_count <= free_count + 1'b1;
            end
            else if (alloc && !free)
            begin
                free_count <= free_count - 1'b1;
            end
        end
    end

    // The reserve must hold every request issued once almost full has been seen
    assert property (@(posedge clk) disable iff (reset) alloc |-> (free_count != '0))
        else $error("write heap allocation from an empty free list");

    // A slot that returns while the list is full has been freed twice by the replay stage
    assert property (@(posedge clk) disable iff (reset)
                     free |-> (free_count != t_cnt'(n_entries)))
        else $error("write heap slot freed with the free list already full");

endmodule

`default_nettype wire

// ==== hw/write_heap_data.sv ====
// Write heap line storage, indexed by slot and beat number, with a registered read
`default_nettype none

module write_heap_data
  #(
    parameter int n_entries = 32
    )
   (
    input  logic clk,

    // Write port from the accelerator side
    input  logic wen,
    input  logic [$clog2(n_entries)-1:0] widx,
    input  afu_edge_pkg::t_cl_num wclnum,
    input  afu_edge_pkg::t_line_data wdata,

    // Read port from the replay stage, data one cycle after ren
    input  logic ren,
    input  logic [$clog2(n_entries)-1:0] ridx,
    input  afu_edge_pkg::t_cl_num rclnum,
    output afu_edge_pkg::t_line_data rdata
    );

    import afu_edge_pkg::*;

    localparam int idx_bits = $clog2(n_entries);
    localparam int addr_bits = idx_bits + $bits(t_cl_num);
    localparam int n_lines = n_entries * MAX_BEATS;

    // Each slot owns MAX_BEATS consecutive lines
    t_line_data mem [n_lines];

    logic [addr_bits-1:0] waddr;
    logic [addr_bits-1:0] raddr;

    assign waddr = {widx, wclnum};
    assign raddr = {ridx, rclnum};

    always_ff @(posedge clk)
    begin
        if (wen)
        begin
            mem[waddr] <= wdata;
        end

        if (ren)
        begin
            rdata <= mem[raddr];
        end
    end

endmodule

`default_nettype wire

// ==== hw/afu_write_canon.sv ====
// Accelerator write canonicalizer, heap writer and control packet generator
`default_nettype none

module afu_write_canon
  #(
    parameter int n_entries = 32
    )
   (
    input  logic clk,
    input  logic reset,

    input  afu_edge_pkg::t_wr_beat afu_c1_tx,

    // Allocator handshake
    input  logic [$clog2(n_entries)-1:0] alloc_idx,
    output logic alloc,

    // Heap write port
    output logic heap_wen,
    output logic [$clog2(n_entries)-1:0] heap_widx,
    output afu_edge_pkg::t_cl_num heap_wclnum,
    output afu_edge_pkg::t_line_data heap_wdata,

    // One control packet per write toward the pipeline
    output logic ctrl_valid,
    output afu_edge_pkg::t_wr_ctrl ctrl
    );

    import afu_edge_pkg::*;

    // ============================
    // Packet tracking
    // ============================

    // Beat number expected on the next non-start beat
    t_cl_num next_cl_num;
    logic packet_active;

    // Header captured from the start beat
    t_line_addr sop_address;
    t_cl_len sop_cl_len;

    // Canonical header and beat number of the current beat
    t_line_addr canon_address;
    t_cl_len canon_cl_len;
    t_cl_num beat_num;
    logic eop;

    always_comb
    begin
        if (afu_c1_tx.sop)
        begin
            canon_address = afu_c1_tx.address;
            canon_cl_len = afu_c1_tx.cl_len;
            beat_num = '0;
        end
        else
        begin
            // Non-start beats may carry anything in address and cl_len
            canon_address = sop_address;
            canon_cl_len = sop_cl_len;
            beat_num = next_cl_num;
        end

        // cl_len holds the index of the last beat
        eop = (beat_num == t_cl_num'(canon_cl_len));
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            next_cl_num <= '0;
            packet_active <= 1'b0;
        end
        else if (afu_c1_tx.valid)
        begin
            next_cl_num <= eop ? '0 : beat_num + 1'b1;
            packet_active <= !eop;
        end
    end

    always_ff @(posedge clk)
    begin
        if (afu_c1_tx.valid && afu_c1_tx.sop)
        begin
            sop_address <= afu_c1_tx.address;
            sop_cl_len <= afu_c1_tx.cl_len;
        end
    end

    // ============================
    // Heap and control packet
    // ============================

    // The slot on offer stays fixed until alloc, so all beats land in one slot
    assign heap_wen = afu_c1_tx.valid;
    assign heap_widx = alloc_idx;
    assign heap_wclnum = beat_num;
    assign heap_wdata = afu_c1_tx.data;

    // Claim the slot only once the final beat is stored
    assign alloc = afu_c1_tx.valid && eop;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ctrl_valid <= 1'b0;
        end
        else
        begin
            ctrl_valid <= alloc;
        end
    end

    always_ff @(posedge clk)
    begin
        if (alloc)
        begin
            ctrl.address <= canon_address;
            ctrl.cl_len <= canon_cl_len;
            ctrl.heap_idx <= 8'(alloc_idx);
        end
    end

    // A new packet may start only after the previous one has seen all its beats
    assert property (@(posedge clk) disable iff (reset)
                     (afu_c1_tx.valid && afu_c1_tx.sop) |-> !packet_active)
        else $error("write start beat inside an open packet");

    // Continuation beats need a start beat earlier in the stream
    assert property (@(posedge clk) disable iff (reset)
                     (afu_c1_tx.valid && !afu_c1_tx.sop) |-> packet_active)
        else $error("write continuation beat without an open packet");

    // Multi-line writes cover an aligned group of lines
    assert property (@(posedge clk) disable iff (reset)
                     (afu_c1_tx.valid && afu_c1_tx.sop) |->
                     ((afu_c1_tx.address[1:0] & 2'(afu_c1_tx.cl_len)) == 2'b00))
        else $error("multi-beat write address not naturally aligned");

endmodule

`default_nettype wire

// ==== hw/mpf_queue.sv ====
// Generic circular FIFO with an occupancy threshold, standing in for the shim pipeline
`default_nettype none

module mpf_queue
  #(
    parameter int depth = 32,
    parameter type t_payload = logic,
    parameter int threshold = 8
    )
   (
    input  logic clk,
    input  logic reset,

    input  logic enq,
    input  t_payload enq_data,

    input  logic deq,
    output t_payload first,
    output logic not_empty,

    // High once only threshold free entries remain
    output logic alm_full
    );

    localparam int ptr_bits = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_bits = $clog2(depth + 1);

    typedef logic [ptr_bits-1:0] t_ptr;
    typedef logic [cnt_bits-1:0] t_cnt;

    localparam t_ptr last_slot = t_ptr'(depth - 1);
    localparam t_cnt alm_level = t_cnt'(depth - threshold);

    t_payload mem [depth];
    t_ptr wr_ptr;
    t_ptr rd_ptr;
    t_cnt count;
    logic do_deq;

    assign do_deq = deq && not_empty;
    assign first = mem[rd_ptr];
    assign not_empty = (count != '0);
    assign alm_full = (count >= alm_level);

    always_ff @(posedge clk)
    begin
        if (enq)
        begin
            mem[wr_ptr] <= enq_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (enq)
            begin
                wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
            end

            if (do_deq)
            begin
                rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
            end

            if (enq && !do_deq)
            begin
                count <= count + 1'b1;
            end
            else if (!enq && do_deq)
            begin
                count <= count - 1'b1;
            end
        end
    end

    // The threshold must absorb everything sent after alm_full rises
    assert property (@(posedge clk) disable iff (reset) enq |-> (count != t_cnt'(depth)))
        else $error("queue overflow");

    assert property (@(posedge clk) disable iff (reset) deq |-> not_empty)
        else $error("queue dequeue while empty");

endmodule

`default_nettype wire

// ==== hw/fiu_write_replay.sv ====
// Host-side write replay FSM that rebuilds every beat from the control packet and heap
`default_nettype none

module fiu_write_replay
  #(
    parameter int n_entries = 32
    )
   (
    input  logic clk,
    input  logic reset,

    // Head of the write control queue
    input  afu_edge_pkg::t_wr_ctrl ctrl,
    input  logic ctrl_valid,
    input  logic fiu_c1_alm_full,
    output logic ctrl_deq,

    // Heap read port, data returns one cycle later
    output logic heap_ren,
    output logic [$clog2(n_entries)-1:0] heap_ridx,
    output afu_edge_pkg::t_cl_num heap_rclnum,
    input  afu_edge_pkg::t_line_data heap_rdata,

    // Slot release toward the allocator
    output logic free,
    output logic [$clog2(n_entries)-1:0] free_idx,

    output afu_edge_pkg::t_wr_beat fiu_c1_tx
    );

    import afu_edge_pkg::*;

    localparam int idx_bits = $clog2(n_entries);

    typedef enum logic
    {
        state_idle,
        state_replay
    } t_state;

    t_state state;

    // Beat read from the heap this cycle, zero while idle
    t_cl_num rd_num;
    logic reading;
    logic last;

    // Header of the beat whose data arrives from the heap this cycle
    logic out_valid;
    logic out_sop;
    t_line_addr out_address;
    t_cl_len out_cl_len;
    t_cl_num out_cl_num;

    // Host flow control is checked only before a packet starts
    // Once started, the remaining beats follow back to back
    always_comb
    begin
        reading = (state == state_replay) || (ctrl_valid && !fiu_c1_alm_full);
        last = reading && (rd_num == t_cl_num'(ctrl.cl_len));
    end

    assign heap_ren = reading;
    assign heap_ridx = ctrl.heap_idx[idx_bits-1:0];
    assign heap_rclnum = rd_num;

    // The last read is already under way, so the slot can go back right away
    assign ctrl_deq = last;
    assign free = last;
    assign free_idx = heap_ridx;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= state_idle;
            rd_num <= '0;
            out_valid <= 1'b0;
        end
        else
        begin
            out_valid <= reading;

            if (last)
            begin
                state <= state_idle;
                rd_num <= '0;
            end
            else if (reading)
            begin
                state <= state_replay;
                rd_num <= rd_num + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reading)
        begin
            out_sop <= (rd_num == '0);
            out_address <= ctrl.address;
            out_cl_len <= ctrl.cl_len;
            out_cl_num <= rd_num;
        end
    end

    always_comb
    begin
        fiu_c1_tx.valid = out_valid;
        fiu_c1_tx.sop = out_sop;
        fiu_c1_tx.address = out_address;
        fiu_c1_tx.cl_len = out_cl_len;
        fiu_c1_tx.cl_num = out_cl_num;
        fiu_c1_tx.data = heap_rdata;
    end

    // The packet being replayed stays at the head of the write queue until its last beat
    assert property (@(posedge clk) disable iff (reset) (state == state_replay) |-> ctrl_valid)
        else $error("write control packet lost during replay");

endmodule

`default_nettype wire

// ==== hw/afu_edge_top.sv ====
// AFU edge top level with the read and write paths, almost-full registers and delayed AFU reset
`default_nettype none

module afu_edge_top
  #(
    parameter int n_write_heap_entries = 32
    )
   (
    input  logic clk,
    input  logic reset,

    // Accelerator side
    input  afu_edge_pkg::t_rd_req afu_c0_tx,
    input  afu_edge_pkg::t_wr_beat afu_c1_tx,
    output logic afu_c0_alm_full,
    output logic afu_c1_alm_full,
    output logic afu_reset,

    // Host side
    output afu_edge_pkg::t_rd_req fiu_c0_tx,
    output afu_edge_pkg::t_wr_beat fiu_c1_tx,
    input  logic fiu_c0_alm_full,
    input  logic fiu_c1_alm_full
    );

    import afu_edge_pkg::*;

    localparam int idx_bits = $clog2(n_write_heap_entries);

    // Reserve room for the threshold plus one whole multi-line packet in flight
    localparam int heap_min_free = ALM_FULL_THRESHOLD + MAX_BEATS + 1;

    // Extra margin covers the almost-full register and the canonicalizer stage
    localparam int queue_threshold = ALM_FULL_THRESHOLD + 4;
    localparam int rd_queue_depth = 32;

    logic alloc;
    logic [idx_bits-1:0] alloc_idx;
    logic heap_not_full;
    logic heap_free;
    logic [idx_bits-1:0] free_idx;

    logic heap_wen;
    logic [idx_bits-1:0] heap_widx;
    t_cl_num heap_wclnum;
    t_line_data heap_wdata;
    logic heap_ren;
    logic [idx_bits-1:0] heap_ridx;
    t_cl_num heap_rclnum;
    t_line_data heap_rdata;

    logic ctrl_valid;
    t_wr_ctrl ctrl;
    t_wr_ctrl wr_first;
    logic wr_not_empty;
    logic wr_alm_full;
    logic wr_deq;

    t_rd_req rd_first;
    logic rd_not_empty;
    logic rd_alm_full;
    logic rd_deq;

    // ============================
    // Write path
    // ============================

    write_heap_ctrl
      #(
        .n_entries(n_write_heap_entries),
        .min_free_slots(heap_min_free)
        )
      heap_ctrl
       (
        .clk,
        .reset,
        .alloc,
        .alloc_idx,
        .not_full(heap_not_full),
        .free(heap_free),
        .free_idx
        );

    write_heap_data
      #(
        .n_entries(n_write_heap_entries)
        )
      heap_data
       (
        .clk,
        .wen(heap_wen),
        .widx(heap_widx),
        .wclnum(heap_wclnum),
        .wdata(heap_wdata),
        .ren(heap_ren),
        .ridx(heap_ridx),
        .rclnum(heap_rclnum),
        .rdata(heap_rdata)
        );

    afu_write_canon
      #(
        .n_entries(n_write_heap_entries)
        )
      write_canon
       (
        .clk,
        .reset,
        .afu_c1_tx,
        .alloc_idx,
        .alloc,
        .heap_wen,
        .heap_widx,
        .heap_wclnum,
        .heap_wdata,
        .ctrl_valid,
        .ctrl
        );

    // Outstanding writes are bounded by the heap, so one entry per slot suffices
    mpf_queue
      #(
        .depth(n_write_heap_entries),
        .t_payload(t_wr_ctrl),
        .threshold(queue_threshold)
        )
      wr_queue
       (
        .clk,
        .reset,
        .enq(ctrl_valid),
        .enq_data(ctrl),
        .deq(wr_deq),
        .first(wr_first),
        .not_empty(wr_not_empty),
        .alm_full(wr_alm_full)
        );

    fiu_write_replay
      #(
        .n_entries(n_write_heap_entries)
        )
      write_replay
       (
        .clk,
        .reset,
        .ctrl(wr_first),
        .ctrl_valid(wr_not_empty),
        .fiu_c1_alm_full,
        .ctrl_deq(wr_deq),
        .heap_ren,
        .heap_ridx,
        .heap_rclnum,
        .heap_rdata,
        .free(heap_free),
        .free_idx,
        .fiu_c1_tx
        );

    // ============================
    // Read path
    // ============================

    mpf_queue
      #(
        .depth(rd_queue_depth),
        .t_payload(t_rd_req),
        .threshold(queue_threshold)
        )
      rd_queue
       (
        .clk,
        .reset,
        .enq(afu_c0_tx.valid),
        .enq_data(afu_c0_tx),
        .deq(rd_deq),
        .first(rd_first),
        .not_empty(rd_not_empty),
        .alm_full(rd_alm_full)
        );

    assign rd_deq = rd_not_empty && !fiu_c0_alm_full;

    // Output register gives reads their two-cycle minimum latency
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            fiu_c0_tx.valid <= 1'b0;
        end
        else
        begin
            fiu_c0_tx.valid <= rd_deq;
        end
        fiu_c0_tx.address <= rd_first.address;
        fiu_c0_tx.cl_len <= rd_first.cl_len;
    end

    // ============================
    // Flow control and reset
    // ============================

    // The accelerator leaves reset one cycle after the shim
    // Almost full lags its sources by a cycle, which the thresholds cover
    always_ff @(posedge clk)
    begin
        afu_reset <= reset;

        if (reset)
        begin
            afu_c0_alm_full <= 1'b1;
            afu_c1_alm_full <= 1'b1;
        end
        else
        begin
            afu_c0_alm_full <= rd_alm_full;
            afu_c1_alm_full <= wr_alm_full || !heap_not_full || fiu_c1_alm_full;
        end
    end

endmodule

`default_nettype wire

// ==== tests/afu_edge_tb.sv ====
// Table-driven testbench for the AFU edge with reference queues, compare tasks and a watchdog
`default_nettype none

module afu_edge_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import afu_edge_pkg::*;

    // One stimulus row, idle is the number of quiet cycles before the row
    typedef struct packed
    {
        logic is_wr;
        t_line_addr address;
        t_cl_len cl_len;
        logic [3:0] idle;
        logic bp;
    } t_row;

    localparam int n_rows = 19;

    // Rows with bp set are issued while both host almost-full inputs are held high
    localparam t_row rows [n_rows] = '{
        '{1'b1, 16'h0100, len_1, 4'd0, 1'b0},
        '{1'b1, 16'h0101, len_1, 4'd0, 1'b0},
        '{1'b1, 16'h0102, len_1, 4'd2, 1'b0},
        '{1'b1, 16'h0200, len_2, 4'd0, 1'b0},
        '{1'b1, 16'h0204, len_4, 4'd1, 1'b0},
        '{1'b1, 16'h0306, len_2, 4'd0, 1'b0},
        '{1'b0, 16'h1000, len_1, 4'd0, 1'b0},
        '{1'b0, 16'h1002, len_2, 4'd0, 1'b0},
        '{1'b0, 16'h1004, len_4, 4'd3, 1'b0},
        '{1'b1, 16'h0408, len_4, 4'd0, 1'b0},
        '{1'b0, 16'h1010, len_1, 4'd0, 1'b0},
        '{1'b1, 16'h0500, len_4, 4'd0, 1'b1},
        '{1'b1, 16'h0512, len_2, 4'd0, 1'b1},
        '{1'b0, 16'h2000, len_4, 4'd0, 1'b1},
        '{1'b1, 16'h0520, len_1, 4'd1, 1'b1},
        '{1'b0, 16'h2004, len_1, 4'd0, 1'b1},
        '{1'b1, 16'h0600, len_1, 4'd0, 1'b0},
        '{1'b0, 16'h3000, len_2, 4'd0, 1'b0},
        '{1'b1, 16'h0700, len_4, 4'd0, 1'b0}
    };

    logic clk;
    logic reset;
    t_rd_req afu_c0_tx;
    t_wr_beat afu_c1_tx;
    logic afu_c0_alm_full;
    logic afu_c1_alm_full;
    logic afu_reset;
    t_rd_req fiu_c0_tx;
    t_wr_beat fiu_c1_tx;
    logic fiu_c0_alm_full;
    logic fiu_c1_alm_full;

    // Expected host-side traffic, in the order it must leave
    t_wr_beat exp_wr_q [$];
    string exp_wr_name [$];
    t_rd_req exp_rd_q [$];
    string exp_rd_name [$];

    logic holding;
    logic [31:0] lcg_state;
    int cycle_count;
    int cycle_limit;

    afu_edge_top
      #(
        .n_write_heap_entries(32)
        )
      DUT
       (
        .clk,
        .reset,
        .afu_c0_tx,
        .afu_c1_tx,
        .afu_c0_alm_full,
        .afu_c1_alm_full,
        .afu_reset,
        .fiu_c0_tx,
        .fiu_c1_tx,
        .fiu_c0_alm_full,
        .fiu_c1_alm_full
        );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ============================
    // Helpers
    // ============================

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Lines covered by a packet of the given length
    function automatic int beats_of(t_cl_len len);
        case (len)
            len_1: return 1;
            len_2: return 2;
            len_4: return 4;
            default: return 0;
        endcase
    endfunction

    function automatic string wr_beat_text(t_wr_beat b);
        return $sformatf("{valid %0b sop %0b addr %h len %0d num %0d data %h}",
                         b.valid, b.sop, b.address, b.cl_len, b.cl_num, b.data);
    endfunction

    function automatic string rd_req_text(t_rd_req r);
        return $sformatf("{valid %0b addr %h len %0d}", r.valid, r.address, r.cl_len);
    endfunction

    task automatic report_failure(input string msg);
        $display("TEST FAILED");
        $display("%s", msg);
        $fatal(1, "Stopping at the first failed check");
    endtask

    task automatic check_wr_beat(input string name, input t_wr_beat expected,
                                 input t_wr_beat actual);
        if (actual !== expected)
        begin
            report_failure($sformatf("Mismatch %s: expected %s, actual %s", name,
                                     wr_beat_text(expected), wr_beat_text(actual)));
        end
    endtask

    task automatic check_rd_req(input string name, input t_rd_req expected,
                                input t_rd_req actual);
        if (actual !== expected)
        begin
            report_failure($sformatf("Mismatch %s: expected %s, actual %s", name,
                                     rd_req_text(expected), rd_req_text(actual)));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            report_failure($sformatf("Mismatch %s: expected %b, actual %b",
                                     name, expected, actual));
        end
    endtask

    // One quiet cycle on both accelerator channels
    task automatic idle_cycle();
        @(posedge clk);
        afu_c0_tx <= '0;
        afu_c1_tx <= '0;
    endtask

    task automatic wait_drained();
        while (exp_wr_q.size() != 0 || exp_rd_q.size() != 0)
        begin
            idle_cycle();
        end
    endtask

    // Holds off the next request while its channel reports almost full
    // The flag is read mid-cycle, after the edge that updates it
    task automatic wait_for_credit(input logic is_wr);
        logic alm_full;
        @(negedge clk);
        alm_full = is_wr ? afu_c1_alm_full : afu_c0_alm_full;
        while (!holding && alm_full)
        begin
            idle_cycle();
            @(negedge clk);
            alm_full = is_wr ? afu_c1_alm_full : afu_c0_alm_full;
        end
    endtask

    // Nothing may be in flight when the host starts pushing back
    task automatic start_hold();
        wait_drained();
        @(posedge clk);
        afu_c0_tx <= '0;
        afu_c1_tx <= '0;
        fiu_c0_alm_full <= 1'b1;
        fiu_c1_alm_full <= 1'b1;
        holding = 1'b1;
    endtask

    task automatic release_hold();
        repeat (6) idle_cycle();
        @(negedge clk);
        check_flag("afu_c1_alm_full under host back-pressure", 1'b1, afu_c1_alm_full);
        @(posedge clk);
        afu_c0_tx <= '0;
        afu_c1_tx <= '0;
        fiu_c0_alm_full <= 1'b0;
        fiu_c1_alm_full <= 1'b0;
        holding = 1'b0;
    endtask

    // Expected beats carry the start header, the driven ones get noise after beat 0
    task automatic send_write(input t_row row, input int r);
        t_wr_beat exp;
        t_wr_beat beat;
        logic [31:0] noise;
        for (int k = 0; k < beats_of(row.cl_len); k++)
        begin
            exp.valid = 1'b1;
            exp.sop = (k == 0);
            exp.address = row.address;
            exp.cl_len = row.cl_len;
            exp.cl_num = t_cl_num'(k);
            exp.data[63:32] = lcg_next();
            exp.data[31:0] = lcg_next();
            beat = exp;
            if (k != 0)
            begin
                noise = lcg_next();
                beat.address = noise[31:16];
                beat.cl_len = t_cl_len'(noise[1:0]);
            end
            exp_wr_q.push_back(exp);
            exp_wr_name.push_back($sformatf("row %0d write beat %0d", r, k));
            @(posedge clk);
            afu_c1_tx <= beat;
            afu_c0_tx <= '0;
        end
    endtask

    task automatic send_read(input t_row row, input int r);
        t_rd_req req;
        req.valid = 1'b1;
        req.address = row.address;
        req.cl_len = row.cl_len;
        exp_rd_q.push_back(req);
        exp_rd_name.push_back($sformatf("row %0d read", r));
        @(posedge clk);
        afu_c0_tx <= req;
        afu_c1_tx <= '0;
    endtask

    // ============================
    // Output monitor and watchdog
    // ============================

    always @(negedge clk)
    begin
        if (!reset)
        begin
            if (fiu_c1_tx.valid === 1'b1)
            begin
                if (holding)
                    report_failure("A write beat left while the host write channel was held");
                else if (exp_wr_q.size() == 0)
                    report_failure("A write beat left with no write outstanding");
                else
                    check_wr_beat(exp_wr_name.pop_front(), exp_wr_q.pop_front(), fiu_c1_tx);
            end
            if (fiu_c0_tx.valid === 1'b1)
            begin
                if (holding)
                    report_failure("A read left while the host read channel was held");
                else if (exp_rd_q.size() == 0)
                    report_failure("A read left with no read outstanding");
                else
                    check_rd_req(exp_rd_name.pop_front(), exp_rd_q.pop_front(), fiu_c0_tx);
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit)
        begin
            report_failure($sformatf("Timeout after %0d cycles", cycle_count));
        end
    end

    // ============================
    // Main sequence
    // ============================

    initial
    begin
        int total_beats;
        reset = 1'b1;
        afu_c0_tx = '0;
        afu_c1_tx = '0;
        fiu_c0_alm_full = 1'b0;
        fiu_c1_alm_full = 1'b0;
        holding = 1'b0;
        lcg_state = 32'd43661;
        cycle_count = 0;
        total_beats = 0;
        for (int r = 0; r < n_rows; r++)
        begin
            total_beats += beats_of(rows[r].cl_len);
        end
        cycle_limit = 20 * total_beats + 200;

        // Outputs take their reset values on the first rising edge
        @(posedge clk);

        // Reset is seen on four rising edges
        for (int c = 0; c < 3; c++)
        begin
            @(negedge clk);
            check_flag("afu_c0_alm_full in reset", 1'b1, afu_c0_alm_full);
            check_flag("afu_c1_alm_full in reset", 1'b1, afu_c1_alm_full);
            check_flag("afu_reset in reset", 1'b1, afu_reset);
            check_flag("fiu_c0_tx.valid in reset", 1'b0, fiu_c0_tx.valid);
            check_flag("fiu_c1_tx.valid in reset", 1'b0, fiu_c1_tx.valid);
        end
        @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_flag("afu_reset one cycle after reset falls", 1'b1, afu_reset);
        @(negedge clk);
        check_flag("afu_reset released", 1'b0, afu_reset);

        for (int r = 0; r < n_rows; r++)
        begin
            if (rows[r].bp && !holding)
                start_hold();
            else if (!rows[r].bp && holding)
                release_hold();

            repeat (rows[r].idle) idle_cycle();

            // Outside a hold the sender respects almost full
            wait_for_credit(rows[r].is_wr);
            if (rows[r].is_wr)
            begin
                send_write(rows[r], r);
            end
            else
            begin
                send_read(rows[r], r);
            end
        end

        if (holding)
            release_hold();
        wait_drained();

        // A few quiet cycles catch any extra beat after the last expected one
        repeat (10) idle_cycle();

        // Every heap slot is back and both queues are empty, so neither channel pushes back
        @(negedge clk);
        check_flag("afu_c0_alm_full after drain", 1'b0, afu_c0_alm_full);
        check_flag("afu_c1_alm_full after drain", 1'b0, afu_c1_alm_full);

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
hw/afu_edge_pkg.sv
hw/write_heap_ctrl.sv
hw/write_heap_data.sv
hw/afu_write_canon.sv
hw/mpf_queue.sv
hw/fiu_write_replay.sv
hw/afu_edge_top.sv
tests/afu_edge_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the AFU edge testbench, the exit status carries pass or fail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module afu_edge_tb -o afu_edge_tb && ./obj_dir/afu_edge_tb || exit 1
